// ==== source/snoop_fault_pkg.sv ====
package snoop_fault_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Register-file word
    localparam int REG_W = 32;

    // Snoop address on the AC channel
    localparam int ACE_ADDR_W = 44;

    // Low address bits seen by the window filter
    localparam int FILTER_ADDR_W = 32;

    ////////////////////////////////////////
    // Timing and arming
    ////////////////////////////////////////

    // One delay unit, roughly 1 us at 150 MHz
    localparam int DELAY_UNIT_CYCLES = 150;

    // Snoop-state code that arms the injector
    localparam logic [3:0] INJECTOR_ENABLE_CODE = 4'd10;

    ////////////////////////////////////////
    // Control word encodings
    ////////////////////////////////////////

    typedef enum logic [3:0]
    {
        FUNC_ONE_SHOT   = 4'd0,
        FUNC_CONTINUOUS = 4'd1
    } func_e;

    // Which strobe is withheld, or none for fuzzing
    typedef enum logic [3:0]
    {
        TEST_FUZZING      = 4'd0,
        TEST_HOLD_CRVALID = 4'd1,
        TEST_HOLD_CDVALID = 4'd2,
        TEST_HOLD_CDLAST  = 4'd3
    } test_e;

    typedef struct packed
    {
        logic [13:0] spare;
        logic        con_en;
        logic        osh_en;
        logic        addr_filter_en;
        logic        opcode_filter_en;
        logic [4:0]  crresp;
        func_e       func;
        test_e       test;
        logic        enable;
    } ctrl_fields_t;

    // Same register seen raw or decoded
    typedef union packed
    {
        logic [REG_W-1:0] word;
        ctrl_fields_t     fields;
    } ctrl_reg_u;

    // Snoop response channel towards the interconnect
    typedef struct packed
    {
        logic [4:0] crresp;
        logic       crvalid;
        logic       cdvalid;
        logic       cdlast;
    } snoop_resp_t;

endpackage

// ==== source/snoop_filter.sv ====
`timescale 1ns/1ps

module snoop_filter
(
    input  logic [3:0]                            i_acsnoop,
    input  logic [snoop_fault_pkg::ACE_ADDR_W-1:0] i_acaddr,
    input  snoop_fault_pkg::ctrl_reg_u            i_ctrl,
    input  logic [snoop_fault_pkg::REG_W-1:0]     i_match_opcode,
    input  logic [snoop_fault_pkg::REG_W-1:0]     i_base_addr,
    input  logic [snoop_fault_pkg::REG_W-1:0]     i_addr_size,
    output logic                                  o_pass
);
    import snoop_fault_pkg::*;

    logic [FILTER_ADDR_W-1:0] w_addr_low;
    logic [FILTER_ADDR_W-1:0] w_base;
    logic [FILTER_ADDR_W-1:0] w_limit;
    logic                     w_opcode_hit;
    logic                     w_addr_hit;

    // Opcode match on the low nibble of the match word
    assign w_opcode_hit = (i_acsnoop == i_match_opcode[3:0]);

    ////////////////////////////////////////
    // Address window
    ////////////////////////////////////////

    assign w_addr_low = i_acaddr[FILTER_ADDR_W-1:0];
    assign w_base     = i_base_addr[FILTER_ADDR_W-1:0];

    // Upper bound is exclusive, wraps within the compared width
    assign w_limit    = w_base + i_addr_size[FILTER_ADDR_W-1:0];

    assign w_addr_hit = (w_addr_low >= w_base) && (w_addr_low < w_limit);

    // A disabled filter lets everything through
    assign o_pass = (!i_ctrl.fields.opcode_filter_en || w_opcode_hit) &&
                    (!i_ctrl.fields.addr_filter_en || w_addr_hit);

endmodule

// ==== source/reply_delay_timer.sv ====
`timescale 1ns/1ps

module reply_delay_timer
(
    input  logic                              ace_aclk,
    input  logic                              ace_aresetn,
    input  logic                              i_run,
    input  logic [snoop_fault_pkg::REG_W-1:0] i_delay_units,
    output logic                              o_expired
);
    import snoop_fault_pkg::*;

    logic [2*REG_W-1:0] r_count;
    logic [2*REG_W-1:0] w_target;
    logic               w_match;

    // Delay in clock cycles
    assign w_target = (2*REG_W)'(i_delay_units) * (2*REG_W)'(DELAY_UNIT_CYCLES);

    assign w_match   = (r_count == w_target);
    assign o_expired = i_run && w_match;

    ////////////////////////////////////////
    // Cycle counter
    ////////////////////////////////////////

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            r_count <= '0;
        end
        else if (!i_run || w_match)
        begin
            // Idle or just expired, start over from zero
            r_count <= '0;
        end
        else
        begin
            r_count <= r_count + 1'b1;
        end
    end

endmodule

// ==== source/fault_reply_sequencer.sv ====
`timescale 1ns/1ps

module fault_reply_sequencer
(
    input  logic                              ace_aclk,
    input  logic                              ace_aresetn,
    input  logic                              i_acvalid,
    input  logic                              i_crready,
    input  logic [3:0]                        i_snoop_state,
    input  snoop_fault_pkg::ctrl_reg_u        i_ctrl,
    input  logic                              i_pass,
    input  logic                              i_delay_expired,
    output logic                              o_acready,
    output logic                              o_capture,
    output logic                              o_delay_run,
    output snoop_fault_pkg::snoop_resp_t      o_resp,
    output logic                              o_reply,
    output logic                              o_end,
    output logic [snoop_fault_pkg::REG_W-1:0] o_status
);
    import snoop_fault_pkg::*;

    typedef enum logic [3:0]
    {
        ST_IDLE        = 4'd0,
        ST_FILTER      = 4'd1,
        ST_FUNCTION    = 4'd2,
        ST_DUMMY_REPLY = 4'd3,
        ST_FAULT_WAIT  = 4'd4,
        ST_RESPONSE    = 4'd5,
        ST_DELAY       = 4'd6,
        ST_END_REPLY   = 4'd7
    } state_e;

    state_e      r_state;
    snoop_resp_t r_resp;
    logic        r_reply;
    logic        r_end;
    logic        r_osh_done;
    logic        r_one_shot;
    logic        r_ends_op;

    ////////////////////////////////////////
    // Request acceptance
    ////////////////////////////////////////

    assign o_acready = (r_state == ST_IDLE);

    // Armed, not finished, and a snoop is offered
    assign o_capture = o_acready && i_acvalid &&
                       (i_snoop_state == INJECTOR_ENABLE_CODE) && !r_end;

    assign o_delay_run = (r_state == ST_DELAY);

    assign o_resp   = r_resp;
    assign o_reply  = r_reply;
    assign o_end    = r_end;
    assign o_status = {{(REG_W-1){1'b0}}, r_osh_done};

    ////////////////////////////////////////
    // Reply FSM
    ////////////////////////////////////////

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            r_state    <= ST_IDLE;
            r_resp     <= '0;
            r_reply    <= 1'b0;
            r_end      <= 1'b0;
            r_osh_done <= 1'b0;
            r_one_shot <= 1'b0;
            r_ends_op  <= 1'b0;
        end
        else
        begin
            case (r_state)
                ST_IDLE:
                begin
                    r_reply <= 1'b0;
                    if (o_capture)
                    begin
                        r_state <= ST_FILTER;
                    end
                    // Sticky bits are released only from idle
                    if (r_osh_done && !i_ctrl.fields.osh_en)
                    begin
                        r_osh_done <= 1'b0;
                    end
                    if (r_end && !i_ctrl.fields.enable)
                    begin
                        r_end <= 1'b0;
                    end
                end
                ST_FILTER:
                begin
                    r_state <= i_pass ? ST_FUNCTION : ST_DUMMY_REPLY;
                end
                ST_FUNCTION:
                begin
                    r_one_shot <= 1'b0;
                    r_state    <= ST_DUMMY_REPLY;
                    case (i_ctrl.fields.func)
                        FUNC_ONE_SHOT:
                        begin
                            if (!r_osh_done && i_ctrl.fields.osh_en)
                            begin
                                r_one_shot <= 1'b1;
                                r_state    <= ST_FAULT_WAIT;
                            end
                        end
                        FUNC_CONTINUOUS:
                        begin
                            if (i_ctrl.fields.con_en)
                            begin
                                r_state <= ST_FAULT_WAIT;
                            end
                        end
                        default:
                        begin
                            r_state <= ST_DUMMY_REPLY;
                        end
                    endcase
                end
                ST_DUMMY_REPLY:
                begin
                    // Plain response with crvalid only
                    if (i_crready)
                    begin
                        r_resp.crresp  <= 5'd0;
                        r_resp.crvalid <= 1'b1;
                        r_ends_op      <= 1'b0;
                        r_state        <= ST_END_REPLY;
                    end
                end
                ST_FAULT_WAIT:
                begin
                    if (i_crready)
                    begin
                        // Last fault when one-shot or continuous got switched off
                        r_ends_op <= r_one_shot || !i_ctrl.fields.con_en;
                        r_state   <= ST_RESPONSE;
                    end
                end
                ST_RESPONSE:
                begin
                    if (r_one_shot)
                    begin
                        r_osh_done <= 1'b1;
                    end
                    r_resp.crresp <= i_ctrl.fields.crresp;
                    case (i_ctrl.fields.test)
                        TEST_FUZZING:
                        begin
                            r_resp.crvalid <= 1'b1;
                            r_resp.cdvalid <= 1'b1;
                            r_resp.cdlast  <= 1'b1;
                            r_state        <= ST_END_REPLY;
                        end
                        TEST_HOLD_CRVALID:
                        begin
                            r_resp.cdvalid <= 1'b1;
                            r_resp.cdlast  <= 1'b1;
                            r_state        <= ST_DELAY;
                        end
                        TEST_HOLD_CDVALID:
                        begin
                            r_resp.crvalid <= 1'b1;
                            r_resp.cdlast  <= 1'b1;
                            r_state        <= ST_DELAY;
                        end
                        TEST_HOLD_CDLAST:
                        begin
                            r_resp.crvalid <= 1'b1;
                            r_resp.cdvalid <= 1'b1;
                            r_state        <= ST_DELAY;
                        end
                        default:
                        begin
                            // Unknown test leaves the strobes as they are
                            r_state <= ST_END_REPLY;
                        end
                    endcase
                end
                ST_DELAY:
                begin
                    if (i_delay_expired)
                    begin
                        // Release the withheld strobe but never crvalid
                        case (i_ctrl.fields.test)
                            TEST_HOLD_CDVALID:
                            begin
                                r_resp.cdvalid <= 1'b1;
                            end
                            TEST_HOLD_CDLAST:
                            begin
                                r_resp.cdlast <= 1'b1;
                            end
                        endcase
                        r_state <= ST_END_REPLY;
                    end
                end
                ST_END_REPLY:
                begin
                    r_resp.crvalid <= 1'b0;
                    r_resp.cdvalid <= 1'b0;
                    r_resp.cdlast  <= 1'b0;
                    r_reply        <= 1'b1;
                    if (r_ends_op)
                    begin
                        r_end <= 1'b1;
                    end
                    r_state <= ST_IDLE;
                end
                default:
                begin
                    r_state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/snoop_fault_injector.sv ====
`timescale 1ns/1ps

module snoop_fault_injector
(
    input  logic                                   ace_aclk,
    input  logic                                   ace_aresetn,
    input  logic                                   i_acvalid,
    input  logic [3:0]                             i_acsnoop,
    input  logic [snoop_fault_pkg::ACE_ADDR_W-1:0] i_acaddr,
    input  logic                                   i_crready,
    input  logic [3:0]                             i_snoop_state,
    input  snoop_fault_pkg::ctrl_reg_u             i_ctrl,
    input  logic [snoop_fault_pkg::REG_W-1:0]      i_delay_reg,
    input  logic [snoop_fault_pkg::REG_W-1:0]      i_match_opcode_reg,
    input  logic [snoop_fault_pkg::REG_W-1:0]      i_base_addr_reg,
    input  logic [snoop_fault_pkg::REG_W-1:0]      i_addr_size_reg,
    output logic                                   o_acready,
    output snoop_fault_pkg::snoop_resp_t           o_resp,
    output logic                                   o_reply,
    output logic                                   o_end,
    output logic [snoop_fault_pkg::REG_W-1:0]      o_status
);
    import snoop_fault_pkg::*;

    logic [3:0]            r_acsnoop;
    logic [ACE_ADDR_W-1:0] r_acaddr;
    logic                  w_capture;
    logic                  w_pass;
    logic                  w_delay_run;
    logic                  w_delay_expired;

    // Snoop request held for the filter
    always_ff @(posedge ace_aclk)
    begin
        if (w_capture)
        begin
            r_acsnoop <= i_acsnoop;
            r_acaddr  <= i_acaddr;
        end
    end

    snoop_filter u_filter
    (
        .i_acsnoop      (r_acsnoop),
        .i_acaddr       (r_acaddr),
        .i_ctrl         (i_ctrl),
        .i_match_opcode (i_match_opcode_reg),
        .i_base_addr    (i_base_addr_reg),
        .i_addr_size    (i_addr_size_reg),
        .o_pass         (w_pass)
    );

    reply_delay_timer u_timer
    (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_run         (w_delay_run),
        .i_delay_units (i_delay_reg),
        .o_expired     (w_delay_expired)
    );

    fault_reply_sequencer u_sequencer
    (
        .ace_aclk        (ace_aclk),
        .ace_aresetn     (ace_aresetn),
        .i_acvalid       (i_acvalid),
        .i_crready       (i_crready),
        .i_snoop_state   (i_snoop_state),
        .i_ctrl          (i_ctrl),
        .i_pass          (w_pass),
        .i_delay_expired (w_delay_expired),
        .o_acready       (o_acready),
        .o_capture       (w_capture),
        .o_delay_run     (w_delay_run),
        .o_resp          (o_resp),
        .o_reply         (o_reply),
        .o_end           (o_end),
        .o_status        (o_status)
    );

endmodule

// ==== tb/tb_snoop_fault_cases.svh ====
`ifndef TB_SNOOP_FAULT_CASES_SVH
`define TB_SNOOP_FAULT_CASES_SVH

// Withheld strobe, same numbering as the hold test modes
localparam logic [1:0] HOLD_NONE    = 2'd0;
localparam logic [1:0] HOLD_CRVALID = 2'd1;
localparam logic [1:0] HOLD_CDVALID = 2'd2;
localparam logic [1:0] HOLD_CDLAST  = 2'd3;

localparam int NUM_CASES = 15;
localparam logic [REG_W-1:0] WIN_BASE = 32'h0000_1000;
localparam logic [REG_W-1:0] WIN_SIZE = 32'h0000_0100;

typedef struct packed
{
    logic [REG_W-1:0]      ctrl;
    logic [3:0]            snoop_state;
    logic                  send;
    logic                  stall;
    logic [3:0]            acsnoop;
    logic [ACE_ADDR_W-1:0] acaddr;
    logic [REG_W-1:0]      match_opcode;
    logic [REG_W-1:0]      base_addr;
    logic [REG_W-1:0]      addr_size;
    logic [REG_W-1:0]      delay;
    logic                  exp_reply;
    logic [4:0]            exp_crresp;
    logic [2:0]            exp_strobes;
    logic [1:0]            exp_withheld;
    logic                  exp_end;
    logic                  exp_status;
} case_t;

case_t cases [NUM_CASES];
string case_names [NUM_CASES];
int    case_count = 0;

function automatic logic [REG_W-1:0] make_ctrl
(
    input logic       enable,
    input logic [3:0] test,
    input logic [3:0] func,
    input logic [4:0] crresp,
    input logic       opcode_f,
    input logic       addr_f,
    input logic       osh_en,
    input logic       con_en
);
    ctrl_reg_u u;
    u.word                    = '0;
    u.fields.enable           = enable;
    u.fields.test             = test_e'(test);
    u.fields.func             = func_e'(func);
    u.fields.crresp           = crresp;
    u.fields.opcode_filter_en = opcode_f;
    u.fields.addr_filter_en   = addr_f;
    u.fields.osh_en           = osh_en;
    u.fields.con_en           = con_en;
    return u.word;
endfunction

task automatic add_case
(
    input string                 name,
    input logic [REG_W-1:0]      ctrl,
    input logic [3:0]            snoop_state,
    input logic                  send,
    input logic                  stall,
    input logic [3:0]            acsnoop,
    input logic [ACE_ADDR_W-1:0] acaddr,
    input logic [REG_W-1:0]      match_opcode,
    input logic [REG_W-1:0]      delay,
    input logic                  exp_reply,
    input logic [4:0]            exp_crresp,
    input logic [2:0]            exp_strobes,
    input logic [1:0]            exp_withheld,
    input logic                  exp_end,
    input logic                  exp_status
);
    case_t c;
    c.ctrl         = ctrl;
    c.snoop_state  = snoop_state;
    c.send         = send;
    c.stall        = stall;
    c.acsnoop      = acsnoop;
    c.acaddr       = acaddr;
    c.match_opcode = match_opcode;
    c.base_addr    = WIN_BASE;
    c.addr_size    = WIN_SIZE;
    c.delay        = delay;
    c.exp_reply    = exp_reply;
    c.exp_crresp   = exp_crresp;
    c.exp_strobes  = exp_strobes;
    c.exp_withheld = exp_withheld;
    c.exp_end      = exp_end;
    c.exp_status   = exp_status;
    cases[case_count]      = c;
    case_names[case_count] = name;
    case_count++;
endtask

////////////////////////////////////////
// Case table, run in order
////////////////////////////////////////

// Strobes are {crvalid, cdvalid, cdlast}
task automatic load_cases;
    // Filter misses get a dummy reply
    add_case("opcode_miss", make_ctrl(1, TEST_FUZZING, FUNC_CONTINUOUS, 5'h0a, 1, 0, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h7, 44'h000_0000_1040, 32'h3, 0,
             1, 5'h00, 3'b100, HOLD_NONE, 0, 0);
    add_case("addr_miss", make_ctrl(1, TEST_FUZZING, FUNC_CONTINUOUS, 5'h0a, 0, 1, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h3, 44'h000_0000_1100, 32'h3, 0,
             1, 5'h00, 3'b100, HOLD_NONE, 0, 0);
    add_case("no_filter_hit", make_ctrl(1, TEST_FUZZING, FUNC_CONTINUOUS, 5'h15, 0, 0, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h9, 44'h000_0000_8000, 32'h3, 0,
             1, 5'h15, 3'b111, HOLD_NONE, 0, 0);
    // Upper address bits lie outside the compared window
    add_case("both_filter_hit", make_ctrl(1, TEST_FUZZING, FUNC_CONTINUOUS, 5'h0c, 1, 1, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h3, 44'ha00_0000_10ff, 32'h3, 0,
             1, 5'h0c, 3'b111, HOLD_NONE, 0, 0);
    add_case("stalled_fuzz", make_ctrl(1, TEST_FUZZING, FUNC_CONTINUOUS, 5'h19, 0, 0, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 1, 4'h1, 44'h000_0000_2000, 32'h3, 0,
             1, 5'h19, 3'b111, HOLD_NONE, 0, 0);
    add_case("hold_cdvalid", make_ctrl(1, TEST_HOLD_CDVALID, FUNC_CONTINUOUS, 5'h04, 0, 0, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h1, 44'h000_0000_2000, 32'h3, 1,
             1, 5'h04, 3'b111, HOLD_CDVALID, 0, 0);
    add_case("hold_cdlast", make_ctrl(1, TEST_HOLD_CDLAST, FUNC_CONTINUOUS, 5'h05, 0, 0, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h1, 44'h000_0000_2000, 32'h3, 1,
             1, 5'h05, 3'b111, HOLD_CDLAST, 0, 0);
    add_case("hold_crvalid", make_ctrl(1, TEST_HOLD_CRVALID, FUNC_CONTINUOUS, 5'h06, 0, 0, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h1, 44'h000_0000_2000, 32'h3, 1,
             1, 5'h06, 3'b011, HOLD_CRVALID, 0, 0);
    add_case("unknown_func", make_ctrl(1, TEST_FUZZING, 4'd5, 5'h1f, 0, 0, 0, 1),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h1, 44'h000_0000_2000, 32'h3, 0,
             1, 5'h00, 3'b100, HOLD_NONE, 0, 0);
    add_case("disarmed", make_ctrl(1, TEST_FUZZING, FUNC_CONTINUOUS, 5'h0a, 0, 0, 0, 1),
             4'd3, 1, 0, 4'h1, 44'h000_0000_2000, 32'h3, 0,
             0, 5'h00, 3'b000, HOLD_NONE, 0, 0);
    // One-shot sequence, sticky bits carry over between cases
    add_case("one_shot_fault", make_ctrl(1, TEST_FUZZING, FUNC_ONE_SHOT, 5'h07, 0, 0, 1, 0),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h2, 44'h000_0000_3000, 32'h3, 0,
             1, 5'h07, 3'b111, HOLD_NONE, 1, 1);
    add_case("end_blocks", make_ctrl(1, TEST_FUZZING, FUNC_ONE_SHOT, 5'h07, 0, 0, 1, 0),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h2, 44'h000_0000_3000, 32'h3, 0,
             0, 5'h00, 3'b000, HOLD_NONE, 1, 1);
    add_case("clear_enable", make_ctrl(0, TEST_FUZZING, FUNC_ONE_SHOT, 5'h07, 0, 0, 1, 0),
             INJECTOR_ENABLE_CODE, 0, 0, 4'h2, 44'h000_0000_3000, 32'h3, 0,
             0, 5'h00, 3'b000, HOLD_NONE, 0, 1);
    add_case("one_shot_repeat", make_ctrl(1, TEST_FUZZING, FUNC_ONE_SHOT, 5'h07, 0, 0, 1, 0),
             INJECTOR_ENABLE_CODE, 1, 0, 4'h2, 44'h000_0000_3000, 32'h3, 0,
             1, 5'h00, 3'b100, HOLD_NONE, 0, 1);
    add_case("clear_osh_en", make_ctrl(1, TEST_FUZZING, FUNC_ONE_SHOT, 5'h07, 0, 0, 0, 0),
             INJECTOR_ENABLE_CODE, 0, 0, 4'h2, 44'h000_0000_3000, 32'h3, 0,
             0, 5'h00, 3'b000, HOLD_NONE, 0, 0);
endtask

`endif

// ==== tb/tb_snoop_fault_injector.sv ====
`timescale 1ns/1ps

module tb_snoop_fault_injector;
    import snoop_fault_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 10;
    localparam int ACCEPT_WINDOW = 20;
    localparam int SETTLE_CYCLES = 3;

    logic                  ace_aclk;
    logic                  ace_aresetn;
    logic                  i_acvalid;
    logic [3:0]            i_acsnoop;
    logic [ACE_ADDR_W-1:0] i_acaddr;
    logic                  i_crready;
    logic [3:0]            i_snoop_state;
    ctrl_reg_u             i_ctrl;
    logic [REG_W-1:0]      i_delay_reg;
    logic [REG_W-1:0]      i_match_opcode_reg;
    logic [REG_W-1:0]      i_base_addr_reg;
    logic [REG_W-1:0]      i_addr_size_reg;
    logic                  o_acready;
    snoop_resp_t           o_resp;
    logic                  o_reply;
    logic                  o_end;
    logic [REG_W-1:0]      o_status;

    `include "tb_snoop_fault_cases.svh"

    localparam int TIMEOUT_CYCLES = NUM_CASES * (DELAY_UNIT_CYCLES + 50) * 2;

    integer     seed = 32'h5028_50c1;
    int         errors = 0;
    int         cases_passed = 0;
    int         cases_failed = 0;
    int         cycle_count = 0;
    int         reply_total = 0;
    int         rise_cycle [3] = '{-1, -1, -1};
    logic [4:0] reply_crresp = '0;
    logic [2:0] prev_strobes = '0;
    logic [2:0] cur_strobes;

    snoop_fault_injector uut
    (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_acvalid          (i_acvalid),
        .i_acsnoop          (i_acsnoop),
        .i_acaddr           (i_acaddr),
        .i_crready          (i_crready),
        .i_snoop_state      (i_snoop_state),
        .i_ctrl             (i_ctrl),
        .i_delay_reg        (i_delay_reg),
        .i_match_opcode_reg (i_match_opcode_reg),
        .i_base_addr_reg    (i_base_addr_reg),
        .i_addr_size_reg    (i_addr_size_reg),
        .o_acready          (o_acready),
        .o_resp             (o_resp),
        .o_reply            (o_reply),
        .o_end              (o_end),
        .o_status           (o_status)
    );

    initial
    begin
        ace_aclk = 1'b0;
    end

    always #(CLK_PERIOD/2) ace_aclk = ~ace_aclk;

    ////////////////////////////////////////
    // Cycle counter and timeout
    ////////////////////////////////////////

    always @(posedge ace_aclk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Response monitor
    ////////////////////////////////////////

    assign cur_strobes = {o_resp.crvalid, o_resp.cdvalid, o_resp.cdlast};

    always @(posedge ace_aclk)
    begin
        // crresp taken where a reply starts from all strobes low
        if (cur_strobes != 3'b000 && prev_strobes == 3'b000)
        begin
            reply_crresp <= o_resp.crresp;
        end
        for (int b = 0; b < 3; b++)
        begin
            if (cur_strobes[b] && !prev_strobes[b])
            begin
                rise_cycle[b] <= cycle_count;
            end
        end
        prev_strobes <= cur_strobes;
        if (o_reply)
        begin
            reply_total <= reply_total + 1;
        end
    end

    task automatic check_value
    (
        input string       test_name,
        input string       what,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        if (expected !== actual)
        begin
            $display("CHECK FAILED %s %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Bit position in {crvalid, cdvalid, cdlast}
    function automatic int strobe_index(input logic [1:0] code);
        return 3 - int'(code);
    endfunction

    function automatic logic [2:0] strobes_since(input int mark);
        logic [2:0] seen;
        for (int b = 0; b < 3; b++)
        begin
            seen[b] = (rise_cycle[b] >= mark);
        end
        return seen;
    endfunction

    task automatic run_case(input int idx);
        case_t c;
        string name;
        int    waited;
        int    mark;
        int    replies_before;
        int    stall_cycles;
        int    gap;
        int    errors_before;
        logic  accepted;
        c             = cases[idx];
        name          = case_names[idx];
        errors_before = errors;
        i_ctrl.word        = c.ctrl;
        i_snoop_state      = c.snoop_state;
        i_acsnoop          = c.acsnoop;
        i_acaddr           = c.acaddr;
        i_match_opcode_reg = c.match_opcode;
        i_base_addr_reg    = c.base_addr;
        i_addr_size_reg    = c.addr_size;
        i_delay_reg        = c.delay;
        i_crready          = !c.stall;
        // Idle cycles so sticky bits can clear
        repeat (SETTLE_CYCLES) @(posedge ace_aclk);
        #1;
        mark           = cycle_count;
        replies_before = reply_total;
        accepted       = 1'b0;
        if (c.send)
        begin
            i_acvalid = 1'b1;
            waited    = 0;
            while (!accepted && waited < ACCEPT_WINDOW)
            begin
                @(posedge ace_aclk);
                #1;
                waited++;
                accepted = !o_acready;
            end
            i_acvalid = 1'b0;
            check_value(name, "accepted", c.exp_reply, accepted);
        end
        if (accepted)
        begin
            if (c.stall)
            begin
                stall_cycles = 3 + ($unsigned($random(seed)) % 16);
                repeat (stall_cycles) @(posedge ace_aclk);
                #1;
                check_value(name, "strobes under stall", 3'b000, strobes_since(mark));
                i_crready = 1'b1;
            end
            while (reply_total == replies_before)
            begin
                @(posedge ace_aclk);
                #1;
            end
            repeat (2) @(posedge ace_aclk);
            #1;
            check_value(name, "crresp", c.exp_crresp, reply_crresp);
            check_value(name, "strobes", c.exp_strobes, strobes_since(mark));
            check_value(name, "reply pulses", 1, reply_total - replies_before);
            if (c.exp_withheld == HOLD_CDVALID || c.exp_withheld == HOLD_CDLAST)
            begin
                gap = rise_cycle[strobe_index(c.exp_withheld)] - rise_cycle[2];
                check_value(name, "withheld gap", c.delay * DELAY_UNIT_CYCLES + 1, gap);
            end
        end
        else
        begin
            repeat (2) @(posedge ace_aclk);
            #1;
            check_value(name, "reply pulses", 0, reply_total - replies_before);
        end
        check_value(name, "o_end", c.exp_end, o_end);
        check_value(name, "status bit", c.exp_status, o_status[0]);
        if (errors == errors_before)
        begin
            cases_passed++;
            $display("case %0d %s: ok", idx, name);
        end
        else
        begin
            cases_failed++;
            $display("case %0d %s: FAILED", idx, name);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        ace_aresetn        = 1'b0;
        i_acvalid          = 1'b0;
        i_acsnoop          = '0;
        i_acaddr           = '0;
        i_crready          = 1'b0;
        i_snoop_state      = '0;
        i_ctrl.word        = '0;
        i_delay_reg        = '0;
        i_match_opcode_reg = '0;
        i_base_addr_reg    = '0;
        i_addr_size_reg    = '0;
        load_cases();
        repeat (RESET_CYCLES) @(posedge ace_aclk);
        #1;
        ace_aresetn = 1'b1;
        check_value("reset", "o_resp", 0, o_resp);
        check_value("reset", "o_reply", 0, o_reply);
        check_value("reset", "o_end", 0, o_end);
        check_value("reset", "o_status", 0, o_status);
        check_value("reset", "o_acready", 1, o_acready);
        for (int i = 0; i < NUM_CASES; i++)
        begin
            run_case(i);
        end
        $display("%0d cases passed, %0d cases failed, %0d check errors",
                 cases_passed, cases_failed, errors);
        if (errors == 0 && cases_failed == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== snoop_fault_injector.f ====
+incdir+tb
source/snoop_fault_pkg.sv
source/snoop_filter.sv
source/reply_delay_timer.sv
source/fault_reply_sequencer.sv
source/snoop_fault_injector.sv
tb/tb_snoop_fault_injector.sv
